//--- cache_stats.sv
module cache_stats import icache_pkg::*; (
    input  logic        clk,
    input  logic        rstn,
    input  logic        hit_pulse,
    input  logic        miss_pulse,
    input  ctrl_state_t state,
    output stats_t      stats
);

    // holds at all ones once full
    function automatic logic [STAT_WIDTH-1:0] sat_inc(input logic [STAT_WIDTH-1:0] v);
        return (&v) ? v : v + 1'b1;
    endfunction

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            stats <= '0;
        end else begin
            if (hit_pulse) begin
                stats.hits <= sat_inc(stats.hits);
            end
            if (miss_pulse) begin
                stats.misses <= sat_inc(stats.misses);
            end
            if (state == ST_REFILL) begin
                stats.refill_cycles <= sat_inc(stats.refill_cycles);
            end
        end
    end

endmodule

//--- icache.f
icache_pkg.sv
load_align.sv
line_store.sv
cache_stats.sv
icache_ctrl.sv
icache_top.sv
tb_icache.sv

//--- icache_ctrl.sv
module icache_ctrl import icache_pkg::*; #(
    parameter int ADDR_WIDTH = 32,
    parameter int LINE_BYTES = 16
) (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  state_reset,
    input  logic                  cpu_req,
    input  logic [ADDR_WIDTH-1:0] cpu_addr,
    input  size_t                 cpu_size,
    input  logic                  cur_hit,
    input  logic [31:0]           hit_word,     // aligned data of the current line
    input  logic                  mem_gnt,
    input  logic                  mem_rvalid,
    input  logic [31:0]           refill_word,  // aligned data of the returning line
    output logic                  cpu_ready,
    output logic [31:0]           cpu_rdata,
    output logic                  cpu_rvalid,
    output logic                  mem_req,
    output logic [ADDR_WIDTH-1:0] mem_addr,
    output logic                  fill_en,
    output logic [ADDR_WIDTH-1:0] pend_addr,
    output size_t                 pend_size,
    output ctrl_state_t           state,
    output logic                  hit_pulse,
    output logic                  miss_pulse
);

    localparam int OFF_BITS = $clog2(LINE_BYTES);

    logic                  hit_now;
    logic                  miss_now;
    logic                  gnt_seen;
    logic                  rsp_valid;
    logic [31:0]           rsp_data;
    logic [ADDR_WIDTH-1:0] req_addr;

    assign hit_now  = cpu_req && (state == ST_IDLE) && cur_hit;
    assign miss_now = cpu_req && (state == ST_IDLE) && !cur_hit;

    // an early rvalid also ends the request phase
    assign mem_req  = miss_now || (state == ST_REFILL && !gnt_seen && !mem_rvalid);
    assign req_addr = miss_now ? cpu_addr : pend_addr;
    assign mem_addr = {req_addr[ADDR_WIDTH-1:OFF_BITS], {OFF_BITS{1'b0}}};

    assign fill_en  = (state == ST_REFILL) && mem_rvalid && !state_reset;

    assign cpu_ready  = (state == ST_IDLE);
    assign cpu_rvalid = hit_now || rsp_valid;
    assign cpu_rdata  = hit_now ? hit_word : rsp_data;

    assign hit_pulse  = hit_now;
    assign miss_pulse = miss_now;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state     <= ST_IDLE;
            gnt_seen  <= 1'b0;
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= fill_en;
            case (state)
                ST_IDLE: begin
                    if (miss_now) begin
                        state    <= ST_REFILL;
                        gnt_seen <= mem_gnt;    // grant may come with the miss
                    end
                end
                ST_REFILL: begin
                    if (mem_gnt || mem_rvalid) begin
                        gnt_seen <= 1'b1;
                    end
                    if (state_reset || mem_rvalid) begin
                        state <= ST_IDLE;       // abort drops the line
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (miss_now) begin
            pend_addr <= cpu_addr;
            pend_size <= cpu_size;
        end
        if (fill_en) begin
            rsp_data <= refill_word;
        end
    end

    a_req_when_ready: assert property (
        @(posedge clk) disable iff (!rstn) cpu_req |-> cpu_ready
    ) else $error("cpu_req while cache not ready");

    a_rvalid_in_refill: assert property (
        @(posedge clk) disable iff (!rstn) mem_rvalid |-> state == ST_REFILL
    ) else $error("mem_rvalid with no refill outstanding");

endmodule

//--- icache_pkg.sv
package icache_pkg;

    // fetch size as presented by the core
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2     // 2'd3 is treated as a word too
    } size_t;

    typedef enum logic {
        ST_IDLE   = 1'b0,
        ST_REFILL = 1'b1     // line requested, waiting for memory
    } ctrl_state_t;

    localparam int STAT_WIDTH = 16;

    typedef struct packed {
        logic [STAT_WIDTH-1:0] hits;
        logic [STAT_WIDTH-1:0] misses;
        logic [STAT_WIDTH-1:0] refill_cycles;
    } stats_t;

endpackage

//--- icache_tests.txt
// columns (hex): address size reset_cycle latency hit data; reset_cycle 0 means no abort
// row ffffffff closes the list: hits misses min_refill_cycles, then two unused zeros
00000100 2 0 2 0 5a5a0100
00000105 0 0 0 1 00000001
0000010a 1 0 0 1 00005a5a
00000113 0 0 1 0 0000005a
12345678 1 0 3 0 00005678
1234567e 0 0 0 1 0000006e
12345672 1 0 0 1 0000486e
00000121 0 0 0 0 00000001
0000012c 2 0 0 1 5a5a012c
00000128 0 0 0 1 00000028
00000207 0 0 2 0 0000005a
00000100 2 0 1 0 5a5a0100
00000138 2 2 0 0 00000000
00000138 2 0 1 0 5a5a0138
12345674 2 0 2 0 486e5674
00000110 2 0 0 1 5a5a0110
00000101 1 0 0 1 00000100
12345670 3 0 0 1 486e5670
12345679 0 0 0 1 00000056
ffffffff a 9 1e 0 0

//--- icache_top.sv
module icache_top import icache_pkg::*; #(
    parameter int ADDR_WIDTH = 32,
    parameter int LINE_BYTES = 16,
    parameter int N_LINES    = 4
) (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    state_reset,
    input  logic                    cpu_req,
    input  logic [ADDR_WIDTH-1:0]   cpu_addr,
    input  size_t                   cpu_size,
    output logic                    cpu_ready,
    output logic [31:0]             cpu_rdata,
    output logic                    cpu_rvalid,
    output logic                    cpu_hit,
    output logic                    mem_req,
    output logic [ADDR_WIDTH-1:0]   mem_addr,
    input  logic                    mem_gnt,
    input  logic                    mem_rvalid,
    input  logic [LINE_BYTES*8-1:0] mem_rdata,
    output stats_t                  stats
);

    localparam int OFF_BITS = $clog2(LINE_BYTES);

    logic                    cur_hit;
    logic [LINE_BYTES*8-1:0] cur_line;
    logic [31:0]             hit_word;
    logic [31:0]             refill_word;
    logic                    fill_en;
    logic [ADDR_WIDTH-1:0]   pend_addr;
    size_t                   pend_size;
    ctrl_state_t             state;
    logic                    hit_pulse;
    logic                    miss_pulse;

    assign cpu_hit = cur_hit;

    icache_ctrl #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .LINE_BYTES (LINE_BYTES)
    ) ctrl_i (
        .clk         (clk),
        .rstn        (rstn),
        .state_reset (state_reset),
        .cpu_req     (cpu_req),
        .cpu_addr    (cpu_addr),
        .cpu_size    (cpu_size),
        .cur_hit     (cur_hit),
        .hit_word    (hit_word),
        .mem_gnt     (mem_gnt),
        .mem_rvalid  (mem_rvalid),
        .refill_word (refill_word),
        .cpu_ready   (cpu_ready),
        .cpu_rdata   (cpu_rdata),
        .cpu_rvalid  (cpu_rvalid),
        .mem_req     (mem_req),
        .mem_addr    (mem_addr),
        .fill_en     (fill_en),
        .pend_addr   (pend_addr),
        .pend_size   (pend_size),
        .state       (state),
        .hit_pulse   (hit_pulse),
        .miss_pulse  (miss_pulse)
    );

    line_store #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .LINE_BYTES (LINE_BYTES),
        .N_LINES    (N_LINES)
    ) store_i (
        .clk       (clk),
        .rstn      (rstn),
        .cur_addr  (cpu_addr),
        .pend_addr (pend_addr),
        .fill_en   (fill_en),
        .fill_line (mem_rdata),
        .cur_hit   (cur_hit),
        .cur_line  (cur_line)
    );

    load_align #(.LINE_BYTES(LINE_BYTES)) hit_align (
        .line     (cur_line),
        .addr_low (cpu_addr[OFF_BITS-1:0]),
        .size     (cpu_size),
        .rdata    (hit_word)
    );

    load_align #(.LINE_BYTES(LINE_BYTES)) refill_align (
        .line     (mem_rdata),              // aligned straight off the bus
        .addr_low (pend_addr[OFF_BITS-1:0]),
        .size     (pend_size),
        .rdata    (refill_word)
    );

    cache_stats stats_i (
        .clk        (clk),
        .rstn       (rstn),
        .hit_pulse  (hit_pulse),
        .miss_pulse (miss_pulse),
        .state      (state),
        .stats      (stats)
    );

endmodule

//--- line_store.sv
module line_store #(
    parameter int ADDR_WIDTH = 32,
    parameter int LINE_BYTES = 16,
    parameter int N_LINES    = 4
) (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic [ADDR_WIDTH-1:0]   cur_addr,
    input  logic [ADDR_WIDTH-1:0]   pend_addr,
    input  logic                    fill_en,
    input  logic [LINE_BYTES*8-1:0] fill_line,
    output logic                    cur_hit,
    output logic [LINE_BYTES*8-1:0] cur_line
);

    localparam int OFF_BITS = $clog2(LINE_BYTES);
    localparam int IDX_BITS = $clog2(N_LINES);
    localparam int TAG_BITS = ADDR_WIDTH - OFF_BITS - IDX_BITS;

    logic                    valid_q [N_LINES];
    logic [TAG_BITS-1:0]     tag_q   [N_LINES];
    logic [LINE_BYTES*8-1:0] data_q  [N_LINES];

    logic [IDX_BITS-1:0] cur_idx;
    logic [TAG_BITS-1:0] cur_tag;
    logic [IDX_BITS-1:0] pend_idx;
    logic [TAG_BITS-1:0] pend_tag;

    assign cur_idx  = cur_addr[OFF_BITS +: IDX_BITS];
    assign cur_tag  = cur_addr[ADDR_WIDTH-1 -: TAG_BITS];
    assign pend_idx = pend_addr[OFF_BITS +: IDX_BITS];
    assign pend_tag = pend_addr[ADDR_WIDTH-1 -: TAG_BITS];

    assign cur_hit  = valid_q[cur_idx] && (tag_q[cur_idx] == cur_tag);
    assign cur_line = data_q[cur_idx];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < N_LINES; i++) begin
                valid_q[i] <= 1'b0;
                tag_q[i]   <= '0;
                data_q[i]  <= '0;
            end
        end else if (fill_en) begin
            valid_q[pend_idx] <= 1'b1;
            tag_q[pend_idx]   <= pend_tag;
            data_q[pend_idx]  <= fill_line;
        end
    end

    a_fill_single: assert property (
        @(posedge clk) disable iff (!rstn) fill_en |=> !fill_en
    ) else $error("back-to-back line fills");

endmodule

//--- load_align.sv
module load_align import icache_pkg::*; #(
    parameter int LINE_BYTES = 16
) (
    input  logic [LINE_BYTES*8-1:0]       line,
    input  logic [$clog2(LINE_BYTES)-1:0] addr_low,
    input  size_t                         size,
    output logic [31:0]                   rdata
);

    localparam int OFF_BITS = $clog2(LINE_BYTES);

    logic [OFF_BITS-1:0] word_idx;
    logic [31:0]         word;

    assign word_idx = addr_low >> 2;
    assign word     = line[word_idx*32 +: 32];  // word 0 at the lsbs

    always_comb begin
        case (size)
            SIZE_BYTE: rdata = {24'h0, word[addr_low[1:0]*8 +: 8]};
            SIZE_HALF: rdata = {16'h0, word[addr_low[1]*16 +: 16]};
            default:   rdata = word;    // word and the spare code
        endcase
    end

endmodule

//--- run_icache.sh
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim_icache.log

verilator --binary --timing --assert -f icache.f --top-module tb_icache -o sim_icache
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_icache > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TESTBENCH FAILED" "$LOG"; then
    exit 1
fi
exit 0

//--- tb_icache.sv
module tb_icache import icache_pkg::*; ();

    localparam int LINE_BITS = 128;
    localparam int MAX_ROWS  = 64;
    localparam int TIMEOUT   = 200;

    logic                 clk;
    logic                 rstn;
    logic                 state_reset;
    logic                 cpu_req;
    logic [31:0]          cpu_addr;
    size_t                cpu_size;
    logic                 cpu_ready;
    logic [31:0]          cpu_rdata;
    logic                 cpu_rvalid;
    logic                 cpu_hit;
    logic                 mem_req;
    logic [31:0]          mem_addr;
    logic                 mem_gnt;
    logic                 mem_rvalid;
    logic [LINE_BITS-1:0] mem_rdata;
    stats_t               stats;

    logic [31:0] vec [MAX_ROWS*6];  // six columns per row
    int          checks;
    int          errors;
    int          failures;

    icache_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // word w of line A is (A + 4w) ^ 5a5a0000
    function automatic logic [LINE_BITS-1:0] line_data(input logic [31:0] line_addr);
        logic [LINE_BITS-1:0] l;
        for (int w = 0; w < LINE_BITS / 32; w++) begin
            l[w*32 +: 32] = (line_addr + 32'(4 * w)) ^ 32'h5a5a0000;
        end
        return l;
    endfunction

    task automatic step();
        @(posedge clk);
        #2;
    endtask

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    // one cycle of ST_REFILL, checked at the falling edge
    task automatic expect_refill(input logic req, input logic [31:0] line_addr);
        @(negedge clk);
        check_val("mem_req", 32'(mem_req), 32'(req));
        check_val("cpu_ready", 32'(cpu_ready), 32'd0);
        check_val("cpu_rvalid", 32'(cpu_rvalid), 32'd0);
        if (req) begin
            check_val("mem_addr", mem_addr, line_addr);
        end
        step();
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        while (cpu_ready !== 1'b1 && n < TIMEOUT) begin
            step();
            n++;
        end
        if (cpu_ready !== 1'b1) begin
            failures++;
            $display("timeout: cpu_ready stayed low for %0d cycles", TIMEOUT);
        end
    endtask

    task automatic fetch(input logic [31:0] addr, input size_t size, input int rst_cycle,
                         input int lat, input logic exp_hit, input logic [31:0] exp_data);
        logic [31:0] line_addr;
        int          gnt_delay;
        line_addr = {addr[31:4], 4'h0};
        wait_ready();
        if (failures != 0) return;
        cpu_req  = 1'b1;
        cpu_addr = addr;
        cpu_size = size;
        @(negedge clk);
        check_val("cpu_hit", 32'(cpu_hit), 32'(exp_hit));
        check_val("cpu_rvalid", 32'(cpu_rvalid), 32'(exp_hit));
        check_val("mem_req", 32'(mem_req), 32'(!exp_hit));
        if (exp_hit) begin
            check_val("cpu_rdata", cpu_rdata, exp_data);
        end else begin
            check_val("mem_addr", mem_addr, line_addr);
        end
        step();
        cpu_req = 1'b0;
        if (exp_hit) return;
        if (rst_cycle != 0) begin
            repeat (rst_cycle - 1) expect_refill(1'b1, line_addr);  // memory holds off
            state_reset = 1'b1;
            expect_refill(1'b1, line_addr);
            state_reset = 1'b0;
            @(negedge clk);
            check_val("cpu_ready", 32'(cpu_ready), 32'd1);
            check_val("cpu_rvalid", 32'(cpu_rvalid), 32'd0);
            step();
            return;
        end
        gnt_delay = int'($urandom % 4);
        repeat (gnt_delay) expect_refill(1'b1, line_addr);
        mem_gnt = 1'b1;
        expect_refill(1'b1, line_addr);
        mem_gnt = 1'b0;
        repeat (lat) expect_refill(1'b0, line_addr);
        mem_rvalid = 1'b1;
        mem_rdata  = line_data(line_addr);
        expect_refill(1'b0, line_addr);
        mem_rvalid = 1'b0;
        mem_rdata  = '0;    // response must come from the register
        @(negedge clk);
        check_val("cpu_rvalid", 32'(cpu_rvalid), 32'd1);
        check_val("cpu_ready", 32'(cpu_ready), 32'd1);
        check_val("cpu_rdata", cpu_rdata, exp_data);
        step();
    endtask

    initial begin
        int b;
        void'($urandom(32'hec067f8e));
        checks      = 0;
        errors      = 0;
        failures    = 0;
        rstn        = 1'b0;
        state_reset = 1'b0;
        cpu_req     = 1'b0;
        cpu_addr    = '0;
        cpu_size    = SIZE_WORD;
        mem_gnt     = 1'b0;
        mem_rvalid  = 1'b0;
        mem_rdata   = '0;
        $readmemh("icache_tests.txt", vec);
        repeat (10) @(posedge clk);
        #2;
        rstn = 1'b1;
        @(negedge clk);
        check_val("cpu_ready", 32'(cpu_ready), 32'd1);
        check_val("mem_req", 32'(mem_req), 32'd0);
        check_val("cpu_rvalid", 32'(cpu_rvalid), 32'd0);
        check_val("stats.misses", 32'(stats.misses), 32'd0);
        step();
        b = 0;
        while (b < MAX_ROWS*6 && vec[b] !== 32'hffffffff && failures == 0) begin
            fetch(vec[b], size_t'(vec[b+1][1:0]), int'(vec[b+2]), int'(vec[b+3]),
                  vec[b+4][0], vec[b+5]);
            b += 6;
        end
        if (failures == 0 && b >= MAX_ROWS*6) begin
            failures++;
            $display("tests file has no totals row");
        end else if (failures == 0) begin
            step();     // let the last strobe land
            check_val("stats.hits", 32'(stats.hits), vec[b+1]);
            check_val("stats.misses", 32'(stats.misses), vec[b+2]);
            checks++;
            assert (32'(stats.refill_cycles) >= vec[b+3]) else begin
                errors++;
                $display("error at %0t: stats.refill_cycles is %h, expected at least %h",
                         $time, stats.refill_cycles, vec[b+3]);
            end
        end
        $display("checks %0d, value errors %0d, other failures %0d", checks, errors, failures);
        if (errors == 0 && failures == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule
